//--- compile.f
+incdir+test
source/loader_map_pkg.sv
source/loader_ctrl_pkg.sv
source/load_classifier.sv
source/prg_address_tracker.sv
source/pointer_injector.sv
source/target_mapper.sv
source/media_loader.sv
test/media_loader_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the media_loader testbench with Verilator, run it, and check for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f compile.f --top-module media_loader_tb --Mdir obj_dir -o media_loader_sim

output=$(./obj_dir/media_loader_sim)
echo "$output"

if echo "$output" | grep -qx "All checks passed"; then
    exit 0
else
    exit 1
fi

//--- source/load_classifier.sv
// Download classifier: index decode into a load kind and end-of-PRG pulse
`timescale 1ns/1ps

module load_classifier (
    input  logic                       clk_sys,
    input  logic                       reset,
    input  logic                       ioctl_download_i,
    input  logic [7:0]                 ioctl_index_i,
    output loader_ctrl_pkg::load_kind_e load_kind_o,
    output logic                       prg_end_o
);

    loader_ctrl_pkg::load_kind_e kind_next;

    // Unknown indexes load nothing
    always_comb begin
        kind_next = loader_ctrl_pkg::LOAD_NONE;
        if (ioctl_download_i) begin
            case (ioctl_index_i)
                loader_ctrl_pkg::IDX_ROM:     kind_next = loader_ctrl_pkg::LOAD_ROM;
                loader_ctrl_pkg::IDX_PRG:     kind_next = loader_ctrl_pkg::LOAD_PRG;
                loader_ctrl_pkg::IDX_PRG_ALT: kind_next = loader_ctrl_pkg::LOAD_PRG;
                loader_ctrl_pkg::IDX_TAP:     kind_next = loader_ctrl_pkg::LOAD_TAP;
                default:                      kind_next = loader_ctrl_pkg::LOAD_NONE;
            endcase
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            load_kind_o <= loader_ctrl_pkg::LOAD_NONE;
            prg_end_o   <= 1'b0;
        end else begin
            load_kind_o <= kind_next;
            // Registered kind still says PRG in the cycle download drops
            prg_end_o   <= (load_kind_o == loader_ctrl_pkg::LOAD_PRG) && !ioctl_download_i;
        end
    end

endmodule

//--- source/loader_ctrl_pkg.sv
// Download control: index codes, load kinds, injection states and settle time
package loader_ctrl_pkg;

    // ==============================
    // Host download index codes
    // ==============================
    localparam logic [7:0] IDX_ROM     = 8'h00;
    localparam logic [7:0] IDX_PRG     = 8'h01;
    localparam logic [7:0] IDX_PRG_ALT = 8'h41;
    localparam logic [7:0] IDX_TAP     = 8'h81;

    typedef enum logic [1:0] {
        LOAD_NONE,
        LOAD_ROM,
        LOAD_PRG,
        LOAD_TAP
    } load_kind_e;

    // Pointer injection sequencer
    typedef enum logic [1:0] {
        INJ_IDLE,
        INJ_WRITE,
        INJ_GAP,
        INJ_SETTLE
    } inject_state_e;

    // Cycles between last pointer write and the reset decision
    localparam int INJECT_SETTLE_CYCLES = 16;

endpackage

//--- source/loader_map_pkg.sv
// Memory map: address widths, load bases, ROM regions, internal bus ranges, BASIC pointers
package loader_map_pkg;

    // ==============================
    // Address widths
    // ==============================
    localparam int ADDR_W       = 23;
    localparam int CPU_ADDR_W   = 16;
    localparam int IOCTL_ADDR_W = 25;

    // ==============================
    // Load bases and limits
    // ==============================
    localparam logic [ADDR_W-1:0]     TAP_MEM_START   = 23'h020000;
    localparam logic [CPU_ADDR_W-1:0] PRG_NOHDR_START = 16'hA000;
    localparam logic [CPU_ADDR_W-1:0] PRG_LIMIT       = 16'hBFFF;

    // ROM image regions in external memory
    localparam logic [ADDR_W-1:0] KERNAL_BASE        = 23'h00E000;
    localparam logic [ADDR_W-1:0] NTSC_KERNAL_OFFSET = 23'h010000;
    localparam logic [ADDR_W-1:0] BASIC_BASE         = 23'h00C000;

    // Character ROM lives behind the memory-setup bus
    localparam logic [CPU_ADDR_W-1:0] CHAR_BASE = 16'h8000;

    // Machine ranges written over the memory-setup bus, not external memory
    localparam int INTERNAL_REGIONS = 3;
    localparam logic [0:INTERNAL_REGIONS-1][CPU_ADDR_W-1:0] INTERNAL_LO =
        {16'h0000, 16'h1000, 16'h9400};
    localparam logic [0:INTERNAL_REGIONS-1][CPU_ADDR_W-1:0] INTERNAL_HI =
        {16'h03FF, 16'h1FFF, 16'h97FF};

    // Zero-page BASIC pointers patched after a program load
    localparam int BASIC_PTR_COUNT = 8;
    localparam logic [0:BASIC_PTR_COUNT-1][CPU_ADDR_W-1:0] BASIC_PTR_ADDRS =
        {16'h002D, 16'h002E, 16'h002F, 16'h0030, 16'h0031, 16'h0032, 16'h00AE, 16'h00AF};

endpackage

//--- source/media_loader.sv
// Media loader top: classifier, PRG tracker, pointer injector and target mapper
`timescale 1ns/1ps

module media_loader (
    input  logic                                    clk_sys,
    input  logic                                    reset,
    input  logic                                    ioctl_download_i,
    input  logic [7:0]                              ioctl_index_i,
    input  logic                                    ioctl_wr_i,
    input  logic [loader_map_pkg::IOCTL_ADDR_W-1:0] ioctl_addr_i,
    input  logic [7:0]                              ioctl_dout_i,
    input  logic                                    no_header_i,
    output logic                                    mem_we_o,
    output logic [loader_map_pkg::ADDR_W-1:0]       mem_addr_o,
    output logic [7:0]                              mem_data_o,
    output logic                                    conf_wr_o,
    output logic [loader_map_pkg::CPU_ADDR_W-1:0]   conf_addr_o,
    output logic [7:0]                              conf_data_o,
    output logic                                    force_reset_o
);

    loader_ctrl_pkg::load_kind_e           load_kind;
    logic                                  prg_end;
    logic                                  prg_wr;
    logic [loader_map_pkg::CPU_ADDR_W-1:0] prg_addr;
    logic [7:0]                            prg_data;
    logic                                  auto_reset;
    logic                                  inj_wr;
    logic [loader_map_pkg::CPU_ADDR_W-1:0] inj_addr;
    logic [7:0]                            inj_data;

    load_classifier u_classifier (
        .clk_sys          (clk_sys),
        .reset            (reset),
        .ioctl_download_i (ioctl_download_i),
        .ioctl_index_i    (ioctl_index_i),
        .load_kind_o      (load_kind),
        .prg_end_o        (prg_end)
    );

    prg_address_tracker u_prg_tracker (
        .clk_sys      (clk_sys),
        .reset        (reset),
        .load_kind_i  (load_kind),
        .ioctl_wr_i   (ioctl_wr_i),
        .ioctl_addr_i (ioctl_addr_i),
        .ioctl_dout_i (ioctl_dout_i),
        .no_header_i  (no_header_i),
        .prg_wr_o     (prg_wr),
        .prg_addr_o   (prg_addr),
        .prg_data_o   (prg_data),
        .auto_reset_o (auto_reset)
    );

    // Final PRG address feeds the BASIC end pointers
    pointer_injector u_injector (
        .clk_sys       (clk_sys),
        .reset         (reset),
        .start_i       (prg_end),
        .prg_addr_i    (prg_addr),
        .auto_reset_i  (auto_reset),
        .inj_wr_o      (inj_wr),
        .inj_addr_o    (inj_addr),
        .inj_data_o    (inj_data),
        .force_reset_o (force_reset_o)
    );

    target_mapper u_mapper (
        .clk_sys      (clk_sys),
        .reset        (reset),
        .load_kind_i  (load_kind),
        .ioctl_wr_i   (ioctl_wr_i),
        .ioctl_addr_i (ioctl_addr_i),
        .ioctl_dout_i (ioctl_dout_i),
        .prg_wr_i     (prg_wr),
        .prg_addr_i   (prg_addr),
        .prg_data_i   (prg_data),
        .inj_wr_i     (inj_wr),
        .inj_addr_i   (inj_addr),
        .inj_data_i   (inj_data),
        .mem_we_o     (mem_we_o),
        .mem_addr_o   (mem_addr_o),
        .mem_data_o   (mem_data_o),
        .conf_wr_o    (conf_wr_o),
        .conf_addr_o  (conf_addr_o),
        .conf_data_o  (conf_data_o)
    );

endmodule

//--- source/pointer_injector.sv
// BASIC pointer injector: eight end-address writes, settle wait, forced reset
`timescale 1ns/1ps

module pointer_injector (
    input  logic                                  clk_sys,
    input  logic                                  reset,
    input  logic                                  start_i,
    input  logic [loader_map_pkg::CPU_ADDR_W-1:0] prg_addr_i,
    input  logic                                  auto_reset_i,
    output logic                                  inj_wr_o,
    output logic [loader_map_pkg::CPU_ADDR_W-1:0] inj_addr_o,
    output logic [7:0]                            inj_data_o,
    output logic                                  force_reset_o
);

    loader_ctrl_pkg::inject_state_e state;
    logic [2:0]                     step;
    logic [4:0]                     settle_cnt;

    // ==============================
    // Sequencer
    // ==============================
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            state         <= loader_ctrl_pkg::INJ_IDLE;
            step          <= '0;
            settle_cnt    <= '0;
            inj_wr_o      <= 1'b0;
            force_reset_o <= 1'b0;
        end else begin
            inj_wr_o      <= 1'b0;
            force_reset_o <= 1'b0;
            case (state)
                loader_ctrl_pkg::INJ_IDLE: begin
                    step <= '0;
                    if (start_i) begin
                        state <= loader_ctrl_pkg::INJ_WRITE;
                    end
                end
                loader_ctrl_pkg::INJ_WRITE: begin
                    inj_wr_o <= 1'b1;
                    state    <= loader_ctrl_pkg::INJ_GAP;
                end
                loader_ctrl_pkg::INJ_GAP: begin
                    if (step == 3'(loader_map_pkg::BASIC_PTR_COUNT - 1)) begin
                        settle_cnt <= '0;
                        state      <= loader_ctrl_pkg::INJ_SETTLE;
                    end else begin
                        step  <= step + 3'd1;
                        state <= loader_ctrl_pkg::INJ_WRITE;
                    end
                end
                loader_ctrl_pkg::INJ_SETTLE: begin
                    settle_cnt <= settle_cnt + 5'd1;
                    if (settle_cnt == 5'(loader_ctrl_pkg::INJECT_SETTLE_CYCLES - 1)) begin
                        // Only cartridges loaded at $A000 restart the machine
                        force_reset_o <= auto_reset_i;
                        state         <= loader_ctrl_pkg::INJ_IDLE;
                    end
                end
                default: state <= loader_ctrl_pkg::INJ_IDLE;
            endcase
        end
    end

    // Even steps carry the low byte, odd steps the high byte
    always_ff @(posedge clk_sys) begin
        if (state == loader_ctrl_pkg::INJ_WRITE) begin
            inj_addr_o <= loader_map_pkg::BASIC_PTR_ADDRS[step];
            inj_data_o <= step[0] ? prg_addr_i[15:8] : prg_addr_i[7:0];
        end
    end

    // A new PRG end must not arrive while a sequence is still running
    assert property (@(posedge clk_sys) disable iff (reset)
        start_i |-> (state == loader_ctrl_pkg::INJ_IDLE));

endmodule

//--- source/prg_address_tracker.sv
// PRG load address tracker: header parse, address walk, cartridge auto-reset flag
`timescale 1ns/1ps

module prg_address_tracker (
    input  logic                                  clk_sys,
    input  logic                                  reset,
    input  loader_ctrl_pkg::load_kind_e           load_kind_i,
    input  logic                                  ioctl_wr_i,
    input  logic [loader_map_pkg::IOCTL_ADDR_W-1:0] ioctl_addr_i,
    input  logic [7:0]                            ioctl_dout_i,
    input  logic                                  no_header_i,
    output logic                                  prg_wr_o,
    output logic [loader_map_pkg::CPU_ADDR_W-1:0] prg_addr_o,
    output logic [7:0]                            prg_data_o,
    output logic                                  auto_reset_o
);

    logic                                  prg_strobe;
    logic                                  first_byte;
    logic                                  byte_wr;
    logic                                  cart_hit;
    logic [loader_map_pkg::CPU_ADDR_W-1:0] addr_next;
    logic [loader_map_pkg::CPU_ADDR_W-1:0] addr_step;

    assign prg_strobe = ioctl_wr_i && (load_kind_i == loader_ctrl_pkg::LOAD_PRG);
    assign first_byte = (ioctl_addr_i == '0);

    // Address stops rising at the top of the cartridge window
    assign addr_step = (prg_addr_o < loader_map_pkg::PRG_LIMIT) ? prg_addr_o + 16'd1
                                                                 : prg_addr_o;

    // Target of the current byte, or the header byte being collected
    always_comb begin
        addr_next = addr_step;
        byte_wr   = 1'b1;
        if (no_header_i) begin
            if (first_byte) begin
                addr_next = loader_map_pkg::PRG_NOHDR_START;
            end
        end else if (first_byte) begin
            addr_next = {prg_addr_o[15:8], ioctl_dout_i};
            byte_wr   = 1'b0;
        end else if (ioctl_addr_i == 1) begin
            addr_next = {ioctl_dout_i, prg_addr_o[7:0]};
            byte_wr   = 1'b0;
        end else if (ioctl_addr_i == 2) begin
            // First data byte lands on the header address itself
            addr_next = prg_addr_o;
        end
    end

    assign cart_hit = byte_wr && (addr_next == loader_map_pkg::PRG_NOHDR_START);

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            prg_wr_o     <= 1'b0;
            prg_addr_o   <= '0;
            auto_reset_o <= 1'b0;
        end else begin
            prg_wr_o <= prg_strobe && byte_wr;
            if (prg_strobe) begin
                prg_addr_o <= addr_next;
                if (first_byte) begin
                    auto_reset_o <= cart_hit;
                end else if (cart_hit) begin
                    auto_reset_o <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (prg_strobe) begin
            prg_data_o <= ioctl_dout_i;
        end
    end

    // No-header loads never run past the cartridge window
    assert property (@(posedge clk_sys) disable iff (reset)
        (prg_strobe && no_header_i) |=> (prg_addr_o <= loader_map_pkg::PRG_LIMIT));

endmodule

//--- source/target_mapper.sv
// Target mapper: ROM/TAP/PRG/pointer bytes to external memory or setup bus
`timescale 1ns/1ps

module target_mapper (
    input  logic                                    clk_sys,
    input  logic                                    reset,
    input  loader_ctrl_pkg::load_kind_e             load_kind_i,
    input  logic                                    ioctl_wr_i,
    input  logic [loader_map_pkg::IOCTL_ADDR_W-1:0] ioctl_addr_i,
    input  logic [7:0]                              ioctl_dout_i,
    input  logic                                    prg_wr_i,
    input  logic [loader_map_pkg::CPU_ADDR_W-1:0]   prg_addr_i,
    input  logic [7:0]                              prg_data_i,
    input  logic                                    inj_wr_i,
    input  logic [loader_map_pkg::CPU_ADDR_W-1:0]   inj_addr_i,
    input  logic [7:0]                              inj_data_i,
    output logic                                    mem_we_o,
    output logic [loader_map_pkg::ADDR_W-1:0]       mem_addr_o,
    output logic [7:0]                              mem_data_o,
    output logic                                    conf_wr_o,
    output logic [loader_map_pkg::CPU_ADDR_W-1:0]   conf_addr_o,
    output logic [7:0]                              conf_data_o
);

    logic                                  ext_we;
    logic                                  int_we;
    logic                                  tap_strobe;
    logic [loader_map_pkg::ADDR_W-1:0]     ext_addr;
    logic [loader_map_pkg::ADDR_W-1:0]     tap_addr;
    logic [loader_map_pkg::ADDR_W-1:0]     tap_next;
    logic [loader_map_pkg::ADDR_W-1:0]     rom_low;
    logic [loader_map_pkg::CPU_ADDR_W-1:0] int_addr;
    logic [7:0]                            wr_data;

    function automatic logic in_internal(input logic [loader_map_pkg::CPU_ADDR_W-1:0] a);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < loader_map_pkg::INTERNAL_REGIONS; i++) begin
            if (a >= loader_map_pkg::INTERNAL_LO[i] && a <= loader_map_pkg::INTERNAL_HI[i]) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    assign tap_strobe = ioctl_wr_i && (load_kind_i == loader_ctrl_pkg::LOAD_TAP);
    assign tap_next   = (ioctl_addr_i == '0) ? loader_map_pkg::TAP_MEM_START : tap_addr + 1'b1;
    assign rom_low    = {{(loader_map_pkg::ADDR_W - 13){1'b0}}, ioctl_addr_i[12:0]};

    // ==============================
    // Write routing
    // ==============================
    always_comb begin
        ext_we   = 1'b0;
        int_we   = 1'b0;
        ext_addr = '0;
        int_addr = '0;
        wr_data  = ioctl_dout_i;
        if (inj_wr_i) begin
            int_we   = 1'b1;
            int_addr = inj_addr_i;
            wr_data  = inj_data_i;
        end else if (prg_wr_i) begin
            wr_data = prg_data_i;
            if (in_internal(prg_addr_i)) begin
                int_we   = 1'b1;
                int_addr = prg_addr_i;
            end else begin
                ext_we   = 1'b1;
                ext_addr = {{(loader_map_pkg::ADDR_W - loader_map_pkg::CPU_ADDR_W){1'b0}},
                            prg_addr_i};
            end
        end else if (tap_strobe) begin
            ext_we   = 1'b1;
            ext_addr = tap_next;
        end else if (ioctl_wr_i && load_kind_i == loader_ctrl_pkg::LOAD_ROM) begin
            // Drive ROM and unmapped regions fall through and are dropped
            case (ioctl_addr_i[15:13])
                3'b010: begin
                    ext_we   = 1'b1;
                    ext_addr = loader_map_pkg::KERNAL_BASE | rom_low;
                end
                3'b011: begin
                    ext_we   = 1'b1;
                    ext_addr = (loader_map_pkg::KERNAL_BASE | loader_map_pkg::NTSC_KERNAL_OFFSET)
                               | rom_low;
                end
                3'b100: begin
                    ext_we   = 1'b1;
                    ext_addr = loader_map_pkg::BASIC_BASE | rom_low;
                end
                3'b101: begin
                    int_we   = 1'b1;
                    int_addr = loader_map_pkg::CHAR_BASE | {4'b0000, ioctl_addr_i[11:0]};
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            mem_we_o  <= 1'b0;
            conf_wr_o <= 1'b0;
            tap_addr  <= loader_map_pkg::TAP_MEM_START;
        end else begin
            mem_we_o  <= ext_we;
            conf_wr_o <= int_we;
            if (tap_strobe) begin
                tap_addr <= tap_next;
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        mem_addr_o  <= ext_addr;
        mem_data_o  <= wr_data;
        conf_addr_o <= int_addr;
        conf_data_o <= wr_data;
    end

    // Injected bytes win the routing, so no PRG or download byte may arrive alongside one
    assert property (@(posedge clk_sys) disable iff (reset)
        !(inj_wr_i && (prg_wr_i || ioctl_wr_i)));

endmodule

//--- test/loader_model.svh
// Reference model: ROM, TAP and PRG write targets, internal ranges, BASIC pointer writes
`ifndef LOADER_MODEL_SVH
`define LOADER_MODEL_SVH

// Expected write packed as {external side, address, data}
function automatic logic [31:0] pack_write(input logic ext, input logic [22:0] addr,
                                           input logic [7:0] data);
    return {ext, addr, data};
endfunction

// Returns 0 when the ROM byte falls in a dropped region
function automatic logic rom_expect(input logic [24:0] off, input logic [7:0] data,
                                    output logic [31:0] entry);
    logic [22:0] low13;
    low13 = {10'd0, off[12:0]};
    entry = '0;
    case (off[15:13])
        3'b010: entry = pack_write(1'b1, loader_map_pkg::KERNAL_BASE + low13, data);
        3'b011: entry = pack_write(1'b1, loader_map_pkg::KERNAL_BASE +
                                   loader_map_pkg::NTSC_KERNAL_OFFSET + low13, data);
        3'b100: entry = pack_write(1'b1, loader_map_pkg::BASIC_BASE + low13, data);
        3'b101: entry = pack_write(1'b0,
                                   {7'd0, loader_map_pkg::CHAR_BASE + {4'd0, off[11:0]}}, data);
        default: return 1'b0;
    endcase
    return 1'b1;
endfunction

function automatic logic [31:0] tap_expect(input int n, input logic [7:0] data);
    return pack_write(1'b1, loader_map_pkg::TAP_MEM_START + 23'(n), data);
endfunction

function automatic logic is_internal(input logic [15:0] addr);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < loader_map_pkg::INTERNAL_REGIONS; i++) begin
        if (addr >= loader_map_pkg::INTERNAL_LO[i] && addr <= loader_map_pkg::INTERNAL_HI[i]) begin
            hit = 1'b1;
        end
    end
    return hit;
endfunction

function automatic logic [31:0] prg_expect(input logic [15:0] addr, input logic [7:0] data);
    return pack_write(!is_internal(addr), {7'd0, addr}, data);
endfunction

// Load address stops rising at the top of the cartridge window
function automatic logic [15:0] prg_advance(input logic [15:0] addr);
    return (addr < loader_map_pkg::PRG_LIMIT) ? addr + 16'd1 : addr;
endfunction

// Even pointers get the low byte of the end address, odd ones the high byte
function automatic logic [31:0] pointer_expect(input logic [2:0] step,
                                               input logic [15:0] end_addr);
    return pack_write(1'b0, {7'd0, loader_map_pkg::BASIC_PTR_ADDRS[step]},
                      step[0] ? end_addr[15:8] : end_addr[7:0]);
endfunction

`endif

//--- test/media_loader_tb.sv
// Testbench for media_loader: LFSR-driven ROM, TAP and PRG downloads checked against a model
`timescale 1ns/1ps

module media_loader_tb;

    localparam int NUM_PRG        = 8;
    localparam int MAX_LEN        = 40;
    localparam int MAX_SPACING    = 4;
    localparam int TIMEOUT_CYCLES = (NUM_PRG + 2) * (MAX_LEN * MAX_SPACING + 100);

    logic        clk_sys;
    logic        reset;
    logic        dl_active;
    logic [7:0]  dl_index;
    logic        dl_wr;
    logic [24:0] dl_addr;
    logic [7:0]  dl_data;
    logic        no_header;
    logic        mem_we;
    logic [22:0] mem_addr;
    logic [7:0]  mem_data;
    logic        conf_wr;
    logic [15:0] conf_addr;
    logic [7:0]  conf_data;
    logic        force_reset;

    logic [31:0] lfsr_state;
    logic [31:0] expect_q[$];
    int          error_count;
    int          reset_pulses;
    int          cycle_count = 0;
    string       test_name;

    `include "loader_model.svh"

    media_loader UUT (
        .clk_sys          (clk_sys),
        .reset            (reset),
        .ioctl_download_i (dl_active),
        .ioctl_index_i    (dl_index),
        .ioctl_wr_i       (dl_wr),
        .ioctl_addr_i     (dl_addr),
        .ioctl_dout_i     (dl_data),
        .no_header_i      (no_header),
        .mem_we_o         (mem_we),
        .mem_addr_o       (mem_addr),
        .mem_data_o       (mem_data),
        .conf_wr_o        (conf_wr),
        .conf_addr_o      (conf_addr),
        .conf_data_o      (conf_data),
        .force_reset_o    (force_reset)
    );

    always #50 clk_sys = ~clk_sys;

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // Header addresses sit just below region bounds so loads cross them
    function automatic logic [15:0] pick_header();
        logic [2:0]  sel;
        logic [15:0] jitter;
        sel    = 3'(take_bits(3));
        jitter = 16'(take_bits(4));
        case (sel)
            3'd0:    return 16'h03F0 + jitter;
            3'd1:    return 16'h0FF0 + jitter;
            3'd2:    return 16'h1FF0 + jitter;
            3'd3:    return 16'h93F0 + jitter;
            3'd4:    return 16'h97F0 + jitter;
            3'd5:    return 16'h9FF0 + jitter;
            3'd6:    return 16'hBFF0 + jitter;
            default: return loader_map_pkg::PRG_NOHDR_START;
        endcase
    endfunction

    // ==============================
    // Write monitor
    // ==============================
    always @(negedge clk_sys) begin
        logic [31:0] actual;
        logic [31:0] expected;
        if (!reset) begin
            if (mem_we && conf_wr) begin
                $display("Both write strobes high at once in %s", test_name);
                error_count++;
            end else if (mem_we || conf_wr) begin
                actual = mem_we ? pack_write(1'b1, mem_addr, mem_data)
                                : pack_write(1'b0, {7'd0, conf_addr}, conf_data);
                if (expect_q.size() == 0) begin
                    $display("Unexpected extra write %h in %s", actual, test_name);
                    error_count++;
                end else begin
                    expected = expect_q.pop_front();
                    if (actual !== expected) begin
                        $display("** Error %s: expected %h, actual %h", test_name, expected, actual);
                        error_count++;
                    end
                end
            end
            if (force_reset) begin
                reset_pulses++;
            end
        end
    end

    always @(posedge clk_sys) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run stopped at cycle limit in %s with %0d writes still missing",
                     test_name, expect_q.size());
            $display("Checks failed");
            $finish;
        end
    end

    task automatic next_cycle();
        @(posedge clk_sys);
        #5;
    endtask

    // One-cycle strobe, then 2 to 4 cycles until the next one
    task automatic send_byte(input logic [24:0] off, input logic [7:0] data);
        int gap;
        gap     = 2 + int'(take_bits(2)) % 3;
        dl_wr   = 1'b1;
        dl_addr = off;
        dl_data = data;
        next_cycle();
        dl_wr = 1'b0;
        repeat (gap - 1) next_cycle();
    endtask

    task automatic begin_download(input logic [7:0] index);
        dl_index  = index;
        dl_active = 1'b1;
        repeat (2) next_cycle();
    endtask

    task automatic end_download();
        dl_active = 1'b0;
        while (expect_q.size() != 0) next_cycle();
    endtask

    // All writes seen, then room for the settle time and a reset pulse
    task automatic settle_check(input int resets_expected);
        while (expect_q.size() != 0) next_cycle();
        repeat (40) next_cycle();
        if (reset_pulses != resets_expected) begin
            $display("Forced reset pulsed %0d times after %s, expected %0d",
                     reset_pulses, test_name, resets_expected);
            error_count++;
        end
        reset_pulses = 0;
    endtask

    // Region bits cycle through all eight ROM slots
    task automatic run_rom();
        logic [24:0] off;
        logic [7:0]  data;
        logic [31:0] entry;
        test_name = "rom";
        begin_download(loader_ctrl_pkg::IDX_ROM);
        for (int i = 0; i < 24; i++) begin
            off  = {9'd0, 3'(i), 13'(take_bits(13))};
            data = 8'(take_bits(8));
            if (rom_expect(off, data, entry)) begin
                expect_q.push_back(entry);
            end
            send_byte(off, data);
        end
        end_download();
        settle_check(0);
    endtask

    task automatic run_tap();
        int         len;
        logic [7:0] data;
        test_name = "tap";
        len       = 4 + int'(take_bits(6)) % 37;
        begin_download(loader_ctrl_pkg::IDX_TAP);
        for (int n = 0; n < len; n++) begin
            data = 8'(take_bits(8));
            expect_q.push_back(tap_expect(n, data));
            send_byte(25'(n), data);
        end
        end_download();
        settle_check(0);
    endtask

    task automatic run_prg(input logic nohdr);
        int          len;
        int          first_data;
        logic [15:0] hdr;
        logic [15:0] addr;
        logic [7:0]  data;
        int          cart;
        test_name  = nohdr ? "prg_noheader" : "prg_header";
        no_header  = nohdr;
        len        = 4 + int'(take_bits(6)) % 37;
        hdr        = pick_header();
        first_data = nohdr ? 0 : 2;
        cart       = 0;
        addr       = nohdr ? loader_map_pkg::PRG_NOHDR_START : hdr;
        begin_download(take_bits(1) ? loader_ctrl_pkg::IDX_PRG_ALT : loader_ctrl_pkg::IDX_PRG);
        for (int n = 0; n < len; n++) begin
            data = 8'(take_bits(8));
            if (!nohdr && n == 0) begin
                data = hdr[7:0];
            end else if (!nohdr && n == 1) begin
                data = hdr[15:8];
            end
            if (n >= first_data) begin
                if (n > first_data) begin
                    addr = prg_advance(addr);
                end
                if (addr == loader_map_pkg::PRG_NOHDR_START) begin
                    cart = 1;
                end
                expect_q.push_back(prg_expect(addr, data));
            end
            send_byte(25'(n), data);
        end
        end_download();
        test_name = "pointers";
        for (int k = 0; k < loader_map_pkg::BASIC_PTR_COUNT; k++) begin
            expect_q.push_back(pointer_expect(3'(k), addr));
        end
        settle_check(cart);
        no_header = 1'b0;
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        clk_sys      = 1'b0;
        reset        = 1'b1;
        dl_active    = 1'b0;
        dl_index     = 8'h00;
        dl_wr        = 1'b0;
        dl_addr      = '0;
        dl_data      = 8'h00;
        no_header    = 1'b0;
        lfsr_state   = 32'hddfe216b;
        error_count  = 0;
        reset_pulses = 0;
        test_name    = "reset";
        repeat (2) @(posedge clk_sys);
        #5;
        reset = 1'b0;
        run_rom();
        run_tap();
        // First two loads fix both header modes, the rest are random
        for (int i = 0; i < NUM_PRG; i++) begin
            run_prg((i < 2) ? 1'(i) : 1'(take_bits(1)));
        end
        $display("Errors: %0d", error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
